//--- include/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// data and address width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_NREGS 32

// first fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

// addi x0, x0, 0 fills every squashed or empty slot
`define RV_NOP 32'h0000_0013

`endif

//--- design/rv_pkg.sv
`default_nettype none

`include "rv_settings.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [$clog2(`RV_NREGS)-1:0] reg_addr_t;

    // major opcodes of the supported groups
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // encoded as {funct7[5], funct3} of the OP group
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b1000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_SRA  = 4'b1101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111
    } alu_op_e;

    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_PC4 = 2'b01,
        RES_IMM = 2'b10
    } result_sel_e;

    // ==============================
    // instruction formats
    // ==============================
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_u;

    // ==============================
    // stage payloads
    // ==============================
    typedef struct packed {
        logic        valid;
        word_t       pc;
        word_t       pc_plus_4;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        reg_addr_t   rd;
        word_t       rdata1;
        word_t       rdata2;
        word_t       imm;
        alu_op_e     alu_op;
        logic        alu_src_imm;
        logic        op1_pc;
        logic [2:0]  funct3;
        logic        is_branch;
        logic        is_jal;
        logic        is_jalr;
        logic        reg_write;
        result_sel_e result_sel;
    } id_ex_t;

    typedef struct packed {
        logic        valid;
        reg_addr_t   rd;
        logic        reg_write;
        result_sel_e result_sel;
        word_t       alu_result;
        word_t       pc_plus_4;
        word_t       imm;
    } ex_res_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

    // value an instruction in the result stage will write back
    function automatic word_t result_value(input ex_res_t r);
        case (r.result_sel)
            RES_PC4: return r.pc_plus_4;
            RES_IMM: return r.imm;
            default: return r.alu_result;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- design/rv_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_settings.svh"

module rv_decode import rv_pkg::*; (
    input  logic   clk,
    input  logic   rst_i,
    input  logic   inst_valid_i,
    input  word_t  inst_i,
    input  word_t  pc_i,
    input  logic   redirect_i,
    input  wb_t    wb_i,
    output id_ex_t id_ex_o
);

    logic    accept;
    inst_u   inst;
    opcode_e opcode;
    logic    legal;
    word_t   imm_i;
    word_t   imm_b;
    word_t   imm_u;
    word_t   imm_j;
    word_t   regs [`RV_NREGS];
    word_t   rdata1;
    word_t   rdata2;
    id_ex_t  id_ex_d;
    id_ex_t  id_ex_q;

    // slot behind a taken branch or jump is dropped
    assign accept = inst_valid_i && !redirect_i;
    assign inst   = accept ? inst_i : `RV_NOP;
    assign opcode = opcode_e'(inst.r_fmt.opcode);

    // ==============================
    // immediates
    // ==============================
    assign imm_i = {{(`RV_XLEN-12){inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
    assign imm_b = {{(`RV_XLEN-12){inst.b_fmt.imm_12}}, inst.b_fmt.imm_11,
                    inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
    assign imm_u = word_t'({inst.u_fmt.imm_31_12, 12'b0});
    assign imm_j = {{(`RV_XLEN-20){inst.j_fmt.imm_20}}, inst.j_fmt.imm_19_12,
                    inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};

    // ==============================
    // register file
    // ==============================
    // x0 reads zero, a write on this edge is seen at once
    function automatic word_t read_port(input logic [4:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (wb_i.valid && wb_i.rd == addr) begin
            return wb_i.data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdata1 = read_port(inst.r_fmt.rs1);
        rdata2 = read_port(inst.r_fmt.rs2);
    end

    always_ff @(posedge clk) begin
        if (wb_i.valid && wb_i.rd != '0) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // ==============================
    // control decode
    // ==============================
    always_comb begin
        id_ex_d           = '0;
        id_ex_d.valid     = accept;
        id_ex_d.pc        = pc_i;
        id_ex_d.pc_plus_4 = pc_i + 'd4;
        id_ex_d.rs1       = inst.r_fmt.rs1;
        id_ex_d.rs2       = inst.r_fmt.rs2;
        id_ex_d.rd        = inst.r_fmt.rd;
        id_ex_d.rdata1    = rdata1;
        id_ex_d.rdata2    = rdata2;
        id_ex_d.funct3    = inst.r_fmt.funct3;
        id_ex_d.alu_op    = ALU_ADD;
        legal             = 1'b1;
        case (opcode)
            OPC_OP: begin
                // funct7[5] only selects sub and sra
                id_ex_d.alu_op    = alu_op_e'({inst.r_fmt.funct7[5] &&
                                    (inst.r_fmt.funct3 == 3'b000 ||
                                     inst.r_fmt.funct3 == 3'b101), inst.r_fmt.funct3});
                id_ex_d.reg_write = 1'b1;
            end
            OPC_OP_IMM: begin
                id_ex_d.alu_op      = alu_op_e'({inst.i_fmt.imm[10] &&
                                      inst.i_fmt.funct3 == 3'b101, inst.i_fmt.funct3});
                id_ex_d.imm         = imm_i;
                id_ex_d.alu_src_imm = 1'b1;
                id_ex_d.reg_write   = 1'b1;
            end
            OPC_LUI: begin
                id_ex_d.imm        = imm_u;
                id_ex_d.result_sel = RES_IMM;
                id_ex_d.reg_write  = 1'b1;
            end
            OPC_AUIPC: begin
                id_ex_d.imm         = imm_u;
                id_ex_d.op1_pc      = 1'b1;
                id_ex_d.alu_src_imm = 1'b1;
                id_ex_d.reg_write   = 1'b1;
            end
            OPC_JAL: begin
                id_ex_d.imm        = imm_j;
                id_ex_d.is_jal     = 1'b1;
                id_ex_d.result_sel = RES_PC4;
                id_ex_d.reg_write  = 1'b1;
            end
            OPC_JALR: begin
                id_ex_d.imm        = imm_i;
                id_ex_d.is_jalr    = 1'b1;
                id_ex_d.result_sel = RES_PC4;
                id_ex_d.reg_write  = 1'b1;
            end
            OPC_BRANCH: begin
                id_ex_d.imm       = imm_b;
                id_ex_d.is_branch = 1'b1;
            end
            default: legal = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        id_ex_q <= id_ex_d;
        if (rst_i) begin
            id_ex_q.valid <= 1'b0;
        end
    end

    assign id_ex_o = id_ex_q;

    // every word that survives the squash must belong to a supported group
    a_legal_opcode : assert property (@(posedge clk) disable iff (rst_i)
        accept |-> legal);

endmodule

`default_nettype wire

//--- design/rv_execute.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_settings.svh"

module rv_execute import rv_pkg::*; (
    input  logic    clk,
    input  logic    rst_i,
    input  id_ex_t  id_ex_i,
    input  wb_t     wb_i,
    output ex_res_t ex_res_o,
    output logic    redirect_o,
    output word_t   redirect_pc_o
);

    ex_res_t    ex_res_d;
    ex_res_t    ex_res_q;
    word_t      src1;
    word_t      src2;
    word_t      op1;
    word_t      op2;
    logic [4:0] shamt;
    word_t      alu_result;
    logic       cond;
    word_t      jump_target;

    // ==============================
    // operand forwarding
    // ==============================
    // distance 1 comes from our own output register, distance 2 from wb
    function automatic word_t forward(input reg_addr_t rs, input word_t rdata,
                                      input ex_res_t ahead, input wb_t wb);
        if (rs == '0) begin
            return rdata;
        end
        if (ahead.valid && ahead.reg_write && ahead.rd == rs) begin
            return result_value(ahead);
        end
        if (wb.valid && wb.rd == rs) begin
            return wb.data;
        end
        return rdata;
    endfunction

    always_comb begin
        src1 = forward(id_ex_i.rs1, id_ex_i.rdata1, ex_res_q, wb_i);
        src2 = forward(id_ex_i.rs2, id_ex_i.rdata2, ex_res_q, wb_i);
    end

    assign op1   = id_ex_i.op1_pc ? id_ex_i.pc : src1;
    assign op2   = id_ex_i.alu_src_imm ? id_ex_i.imm : src2;
    assign shamt = op2[4:0];

    // ==============================
    // alu
    // ==============================
    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD:  alu_result = op1 + op2;
            ALU_SUB:  alu_result = op1 - op2;
            ALU_SLL:  alu_result = op1 << shamt;
            ALU_SLT:  alu_result = word_t'($signed(op1) < $signed(op2));
            ALU_SLTU: alu_result = word_t'(op1 < op2);
            ALU_XOR:  alu_result = op1 ^ op2;
            ALU_SRL:  alu_result = op1 >> shamt;
            ALU_SRA:  alu_result = word_t'($signed(op1) >>> shamt);
            ALU_OR:   alu_result = op1 | op2;
            ALU_AND:  alu_result = op1 & op2;
            default:  alu_result = op1 + op2;
        endcase
    end

    // ==============================
    // branches and jumps
    // ==============================
    always_comb begin
        case (id_ex_i.funct3)
            3'b000:  cond = src1 == src2;
            3'b001:  cond = src1 != src2;
            3'b100:  cond = $signed(src1) < $signed(src2);
            3'b101:  cond = $signed(src1) >= $signed(src2);
            3'b110:  cond = src1 < src2;
            3'b111:  cond = src1 >= src2;
            default: cond = 1'b0;
        endcase
    end

    // jalr is register relative, everything else pc relative
    assign jump_target   = (id_ex_i.is_jalr ? src1 : id_ex_i.pc) + id_ex_i.imm;
    assign redirect_pc_o = {jump_target[`RV_XLEN-1:1], jump_target[0] & ~id_ex_i.is_jalr};
    assign redirect_o    = id_ex_i.valid &&
                           (id_ex_i.is_jal || id_ex_i.is_jalr || (id_ex_i.is_branch && cond));

    // ==============================
    // execute to result register
    // ==============================
    always_comb begin
        ex_res_d.valid      = id_ex_i.valid;
        ex_res_d.rd         = id_ex_i.rd;
        ex_res_d.reg_write  = id_ex_i.reg_write;
        ex_res_d.result_sel = id_ex_i.result_sel;
        ex_res_d.alu_result = alu_result;
        ex_res_d.pc_plus_4  = id_ex_i.pc_plus_4;
        ex_res_d.imm        = id_ex_i.imm;
    end

    always_ff @(posedge clk) begin
        ex_res_q <= ex_res_d;
        if (rst_i) begin
            ex_res_q.valid <= 1'b0;
        end
    end

    assign ex_res_o = ex_res_q;

    // a redirect kills the next slot in decode
    a_redirect_squash : assert property (@(posedge clk) disable iff (rst_i)
        redirect_o |=> !id_ex_i.valid);

endmodule

`default_nettype wire

//--- design/rv_result.sv
`timescale 1ns/10ps
`default_nettype none

module rv_result import rv_pkg::*; (
    input  logic    clk,
    input  logic    rst_i,
    input  ex_res_t ex_res_i,
    output wb_t     wb_o
);

    logic writes;
    wb_t  wb_d;
    wb_t  wb_q;

    // x0 targets and non-writing groups never reach the register file
    assign writes = ex_res_i.valid && ex_res_i.reg_write && ex_res_i.rd != '0;

    // alu for arithmetic and auipc, pc+4 for jumps, imm for lui
    always_comb begin
        wb_d.valid = writes;
        wb_d.rd    = ex_res_i.rd;
        wb_d.data  = result_value(ex_res_i);
    end

    // ==============================
    // result register
    // ==============================
    always_ff @(posedge clk) begin
        wb_q <= wb_d;
        if (rst_i) begin
            wb_q.valid <= 1'b0;
        end
    end

    assign wb_o = wb_q;

    // a register write never carries unknown bits
    a_wb_known : assert property (@(posedge clk) disable iff (rst_i)
        wb_q.valid |-> !$isunknown(wb_q.data));

endmodule

`default_nettype wire

//--- design/rv_core_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_settings.svh"

module rv_core_top import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    input  logic      inst_valid_i,
    input  word_t     inst_i,
    output word_t     pc_o,
    output logic      wb_valid_o,
    output reg_addr_t wb_rd_o,
    output word_t     wb_data_o
);

    word_t   pc_q;
    word_t   pc_d;
    logic    redirect;
    word_t   redirect_pc;
    id_ex_t  id_ex;
    ex_res_t ex_res;
    wb_t     wb;

    // redirect wins over sequential fetch
    always_comb begin
        if (redirect) begin
            pc_d = redirect_pc;
        end else if (inst_valid_i) begin
            pc_d = pc_q + 'd4;
        end else begin
            pc_d = pc_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= `RV_RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign pc_o = pc_q;

    // ==============================
    // stages
    // ==============================
    rv_decode rv_decode_i (
        .clk          (clk),
        .rst_i        (rst_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .pc_i         (pc_q),
        .redirect_i   (redirect),
        .wb_i         (wb),
        .id_ex_o      (id_ex)
    );

    rv_execute rv_execute_i (
        .clk           (clk),
        .rst_i         (rst_i),
        .id_ex_i       (id_ex),
        .wb_i          (wb),
        .ex_res_o      (ex_res),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc)
    );

    rv_result rv_result_i (
        .clk      (clk),
        .rst_i    (rst_i),
        .ex_res_i (ex_res),
        .wb_o     (wb)
    );

    assign wb_valid_o = wb.valid;
    assign wb_rd_o    = wb.rd;
    assign wb_data_o  = wb.data;

endmodule

`default_nettype wire

//--- tests/rv_tb_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_settings.svh"

module rv_tb_top;

    localparam int          PROG_WORDS = 512;
    localparam int          PROLOGUE   = 62;
    localparam int          END_IDX    = 440;
    localparam int          TIMEOUT    = 20000;
    localparam logic [31:0] SEED       = 32'h850b_4aca;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] data;
        int          due;
    } write_t;

    logic        clk;
    logic        rst_i;
    logic        inst_valid_i;
    logic [31:0] inst_i;
    logic [31:0] pc_o;
    logic        wb_valid_o;
    logic [4:0]  wb_rd_o;
    logic [31:0] wb_data_o;

    logic [31:0] prog [PROG_WORDS];
    logic [31:0] xreg [32];
    logic [31:0] model_pc;
    logic        squash;
    logic        done;
    write_t      exp_q [$];
    logic        head_valid;
    logic [4:0]  head_rd;
    logic [31:0] head_data;
    logic        head_on_time;
    int          edge_cnt;
    int          errors;
    int          writes_seen;
    int          cycles;

    rv_core_top rv_core_top_i (
        .clk          (clk),
        .rst_i        (rst_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .pc_o         (pc_o),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o)
    );

    always #5 clk = ~clk;

    // ==============================
    // instruction encoders
    // ==============================
    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] branch_word(input logic [12:0] off, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] jal_word(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    // source register, often the last or second last destination
    function automatic logic [4:0] pick_src(input logic [4:0] near, input logic [4:0] far);
        case ($urandom % 4)
            0: return near;
            1: return far;
            default: return 5'($urandom);
        endcase
    endfunction

    // ==============================
    // program generator
    // ==============================
    task automatic build_program();
        int          i;
        int          k;
        logic [31:0] r;
        logic [2:0]  f3;
        logic [2:0]  bf3;
        logic [3:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  prev_rd;
        logic [4:0]  prev2_rd;
        logic [11:0] imm;
        logic        flow_ok;
        logic        is_target [PROG_WORDS];
        // unused words are nops carrying their own index as immediate
        for (i = 0; i < PROG_WORDS; i++) begin
            prog[i] = i_word(12'(i), 5'd0, 3'd0, 5'd0, 7'h13);
            is_target[i] = 1'b0;
        end
        // every register gets a known value first
        for (i = 1; i < 32; i++) begin
            r = $urandom;
            prog[2 * i - 2] = u_word(r[31:12], 5'(i), 7'h37);
            prog[2 * i - 1] = i_word(r[11:0], 5'(i), 3'd0, 5'(i), 7'h13);
        end
        prev_rd  = 5'd31;
        prev2_rd = 5'd30;
        i = PROLOGUE;
        while (i < END_IDX) begin
            kind    = 4'($urandom);
            r       = $urandom;
            rd      = 5'($urandom);
            rs1     = pick_src(prev_rd, prev2_rd);
            rs2     = pick_src(prev_rd, prev2_rd);
            f3      = 3'($urandom);
            k       = 1 + int'($urandom % 5);
            flow_ok = i + 7 < END_IDX;
            // only forward targets, so the program always runs into its end
            if (kind == 4'd15 && flow_ok && !is_target[i + 1]) begin
                prog[i]     = u_word(20'h0, 5'd31, 7'h17);
                imm         = 12'(4 * (k + 1)) | {11'b0, r[0]};
                prog[i + 1] = i_word(imm, 5'd31, 3'd0, rd, 7'h67);
                is_target[i + 1 + k] = 1'b1;
                i += 2;
            end else begin
                if (kind == 4'd14 && flow_ok) begin
                    prog[i] = jal_word(21'(4 * k), rd);
                    is_target[i + k] = 1'b1;
                end else if (kind >= 4'd12 && flow_ok) begin
                    bf3 = (f3 == 3'd2 || f3 == 3'd3) ? f3 + 3'd2 : f3;
                    prog[i] = branch_word(13'(4 * k), rs2, rs1, bf3);
                    is_target[i + k] = 1'b1;
                end else if (kind == 4'd11) begin
                    prog[i] = u_word(r[31:12], rd, 7'h17);
                end else if (kind == 4'd10) begin
                    prog[i] = u_word(r[31:12], rd, 7'h37);
                end else if (kind >= 4'd6) begin
                    if (f3 == 3'd1 || f3 == 3'd5) begin
                        imm = {1'b0, (f3 == 3'd5) & r[31], 5'b0, r[4:0]};
                    end else begin
                        imm = r[11:0];
                    end
                    prog[i] = i_word(imm, rs1, f3, rd, 7'h13);
                end else begin
                    prog[i] = r_word(((f3 == 3'd0 || f3 == 3'd5) && r[31]) ? 7'h20 : 7'h00,
                                     rs2, rs1, f3, rd);
                end
                i++;
            end
            prev2_rd = prev_rd;
            prev_rd  = rd;
        end
        // parks the core on itself
        prog[END_IDX] = jal_word(21'd0, 5'd0);
    endtask

    // ==============================
    // reference model
    // ==============================
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic execute_inst(input logic [31:0] inst);
        logic [6:0]  op;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic [31:0] val;
        logic        wr;
        logic        jump;
        op    = inst[6:0];
        rd    = inst[11:7];
        f3    = inst[14:12];
        a     = xreg[inst[19:15]];
        b     = xreg[inst[24:20]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_u = {inst[31:12], 12'b0};
        imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        val   = '0;
        wr    = 1'b1;
        jump  = 1'b0;
        if (model_pc == 32'(END_IDX * 4)) begin
            done = 1'b1;
        end
        case (op)
            7'h33: val = alu_ref(f3, inst[30], a, b);
            7'h13: val = alu_ref(f3, inst[30] && f3 == 3'd5, a, imm_i);
            7'h37: val = imm_u;
            7'h17: val = model_pc + imm_u;
            7'h6f: begin
                val  = model_pc + 32'd4;
                jump = 1'b1;
                imm_j = model_pc + imm_j;
            end
            7'h67: begin
                val  = model_pc + 32'd4;
                jump = 1'b1;
                imm_j = (a + imm_i) & ~32'd1;
            end
            7'h63: begin
                wr   = 1'b0;
                jump = branch_taken(f3, a, b);
                imm_j = model_pc + imm_b;
            end
            default: begin
                wr = 1'b0;
                errors++;
                $display("reference model found an unknown opcode %h at pc %h", op, model_pc);
            end
        endcase
        // seen on wb at the third edge after acceptance
        if (wr && rd != 5'd0) begin
            xreg[rd] = val;
            exp_q.push_back(write_t'{rd, val, edge_cnt + 3});
        end
        // the slot after a redirect is dropped by the core
        squash   = jump;
        model_pc = jump ? imm_j : model_pc + 32'd4;
    endtask

    always @(posedge clk) begin
        if (rst_i) begin
            model_pc = `RV_RESET_PC;
            squash   = 1'b0;
            done     = 1'b0;
            edge_cnt = 0;
            exp_q.delete();
            for (int r = 0; r < 32; r++) begin
                xreg[r] = '0;
            end
        end else begin
            edge_cnt++;
            if (wb_valid_o && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
                writes_seen++;
            end
            if (squash) begin
                squash = 1'b0;
            end else begin
                a_pc : assert (pc_o == model_pc)
                    else begin
                        errors++;
                        $display("mismatch pc_o: got %h, expected %h", pc_o, model_pc);
                    end
                if (inst_valid_i) begin
                    execute_inst(prog[model_pc[10:2]]);
                end
            end
        end
        head_valid   = exp_q.size() > 0;
        head_rd      = head_valid ? exp_q[0].rd : 5'd0;
        head_data    = head_valid ? exp_q[0].data : 32'd0;
        head_on_time = head_valid ? exp_q[0].due == edge_cnt + 1 : 1'b0;
    end

    // ==============================
    // write-back checks
    // ==============================
    a_wb_expected : assert property (@(posedge clk) disable iff (rst_i)
        wb_valid_o |-> head_valid)
        else begin
            errors++;
            $display("unexpected register write to x%0d", $sampled(wb_rd_o));
        end

    a_wb_timing : assert property (@(posedge clk) disable iff (rst_i)
        head_valid |-> wb_valid_o == head_on_time)
        else begin
            errors++;
            $display("register write to x%0d did not appear two cycles after decode",
                     $sampled(head_rd));
        end

    a_wb_rd : assert property (@(posedge clk) disable iff (rst_i)
        wb_valid_o && head_valid |-> wb_rd_o == head_rd)
        else begin
            errors++;
            $display("mismatch wb_rd_o: got %h, expected %h", $sampled(wb_rd_o),
                     $sampled(head_rd));
        end

    a_wb_data : assert property (@(posedge clk) disable iff (rst_i)
        wb_valid_o && head_valid |-> wb_data_o == head_data)
        else begin
            errors++;
            $display("mismatch wb_data_o: got %h, expected %h", $sampled(wb_data_o),
                     $sampled(head_data));
        end

    // fetch port answers for the current pc, valid dropped about 1 in 8
    task automatic drive_inputs();
        inst_valid_i = ($urandom % 8) != 0;
        inst_i       = prog[pc_o[10:2]];
    endtask

    initial begin
        clk          = 1'b0;
        rst_i        = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = `RV_NOP;
        errors       = 0;
        writes_seen  = 0;
        void'($urandom(SEED));
        build_program();
        repeat (5) @(posedge clk);
        #1;
        rst_i = 1'b0;
        drive_inputs();
        cycles = 0;
        while (!(done && exp_q.size() == 0) && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            drive_inputs();
            cycles++;
        end
        if (!(done && exp_q.size() == 0)) begin
            errors++;
            $display("pipeline stalled, program did not finish within %0d cycles", TIMEOUT);
        end
        $display("writes checked %0d, errors %0d", writes_seen, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+include
design/rv_pkg.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_result.sv
design/rv_core_top.sv
tests/rv_tb_top.sv

//--- Bender.yml
package:
  name: rv_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/rv_pkg.sv
      - design/rv_decode.sv
      - design/rv_execute.sv
      - design/rv_result.sv
      - design/rv_core_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - tests/rv_tb_top.sv
